// File: l2_cache.f
source/l2_cache_pkg.sv
source/burst_counter.sv
source/tag_array.sv
source/data_array.sv
source/lru_order.sv
source/cache_ctrl.sv
source/l2_cache.sv
verification/tb_clock.sv
verification/tb_mem_model.sv
verification/tb_l2_cache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the l2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module tb_l2_cache \
    -f l2_cache.f -o tb_l2_cache

out=$(./obj_dir/tb_l2_cache)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

// File: source/burst_counter.sv
// word counter for one line transfer
// cleared by start, advanced by step, done at BLOCK_SIZE words
`timescale 1ns/10ps

module burst_counter #(
    parameter int  BLOCK_SIZE = 4,
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                start,     // clear for a new burst
    input  logic                step,      // one word accepted
    output logic [BLOCK_BITS:0] word_idx,  // running word index
    output logic                done       // whole line moved
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_idx <= '0;
        end else if (start) begin
            word_idx <= '0;
        end else if (step && !done) begin
            word_idx <= word_idx + 1'b1;  // holds while memory is busy
        end
    end

    assign done = (word_idx == (BLOCK_BITS+1)'(BLOCK_SIZE));

endmodule

// File: source/cache_ctrl.sv
// cache controller FSM: hit, write-back, fetch and pass-through sequencing
// drives the arrays, the burst counter and both bus sides
`timescale 1ns/10ps

module cache_ctrl import l2_cache_pkg::*; #(
    parameter int    BLOCK_SIZE          = 4,
    parameter int    ASSOC               = 4,
    parameter int    N_SETS              = 8,
    parameter addr_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int   BLOCK_BITS          = $clog2(BLOCK_SIZE),
    localparam int   SET_BITS            = $clog2(N_SETS),
    localparam int   WAY_BITS            = $clog2(ASSOC),
    localparam int   TAG_BITS            = WORD_SIZE - SET_BITS - BLOCK_BITS - 2
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  proc_req_t             proc_req,
    output word_t                 proc_rdata,
    output logic                  proc_busy,
    output mem_req_t              mem_req,
    input  word_t                 mem_rdata,
    input  logic                  mem_busy,
    input  logic                  hit,
    input  logic [WAY_BITS-1:0]   hit_way,
    input  logic [WAY_BITS-1:0]   victim_way,
    input  logic                  victim_dirty,
    input  logic [TAG_BITS-1:0]   victim_tag,
    input  logic [BLOCK_BITS:0]   word_idx,
    input  logic                  burst_done,
    output logic                  burst_start,
    output logic                  burst_step,
    output logic                  tag_we,
    output logic                  tag_dirty_we,
    output logic                  data_we,
    output logic [WAY_BITS-1:0]   data_way,
    output logic [BLOCK_BITS-1:0] data_word,
    output word_t                 data_wdata,
    input  word_t                 rd_word,
    output logic                  lru_access
);
    cache_state_t          state, next_state;
    logic                  access, pass;
    logic [TAG_BITS-1:0]   req_tag;
    logic [SET_BITS-1:0]   req_set;
    logic [BLOCK_BITS-1:0] req_off;

    // address decode: tag | set | word | byte
    assign req_tag = proc_req.addr[WORD_SIZE-1 -: TAG_BITS];
    assign req_set = proc_req.addr[BLOCK_BITS+2 +: SET_BITS];
    assign req_off = proc_req.addr[2 +: BLOCK_BITS];
    assign access  = proc_req.ren | proc_req.wen;
    assign pass    = access && (proc_req.addr >= NONCACHE_START_ADDR);  // uncached region

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_state   = state;
        proc_busy    = 1'b1;
        proc_rdata   = rd_word;
        mem_req      = '0;
        burst_start  = 1'b0;
        burst_step   = 1'b0;
        tag_we       = 1'b0;
        tag_dirty_we = 1'b0;
        data_we      = 1'b0;
        data_way     = victim_way;                   // line transfers use the victim
        data_word    = word_idx[BLOCK_BITS-1:0];
        data_wdata   = mem_rdata;                    // fill data
        lru_access   = 1'b0;
        case (state)
            IDLE: begin
                if (pass) begin
                    mem_req.ren   = proc_req.ren;    // straight through, same cycle
                    mem_req.wen   = proc_req.wen;
                    mem_req.addr  = proc_req.addr;
                    mem_req.wdata = proc_req.wdata;
                    proc_busy     = mem_busy;
                    proc_rdata    = mem_rdata;
                end else if (access) begin
                    burst_start = ~hit;              // zero counter for a line transfer
                    if (hit) begin
                        next_state = HIT;
                    end else if (victim_dirty) begin
                        next_state = WRITE_BACK;
                    end else begin
                        next_state = FETCH;
                    end
                end
            end
            HIT: begin
                proc_busy    = 1'b0;                 // request done this edge
                data_way     = hit_way;
                data_word    = req_off;
                data_wdata   = proc_req.wdata;
                data_we      = proc_req.wen;
                tag_dirty_we = proc_req.wen;         // write hit marks line dirty
                lru_access   = 1'b1;
                next_state   = IDLE;
            end
            WRITE_BACK: begin
                mem_req.addr  = {victim_tag, req_set, data_word, 2'b00};  // old line address
                mem_req.wdata = rd_word;
                if (burst_done) begin
                    burst_start = 1'b1;
                    next_state  = FETCH;
                end else begin
                    mem_req.wen = 1'b1;
                    burst_step  = ~mem_busy;         // word taken
                end
            end
            FETCH: begin
                mem_req.addr = {req_tag, req_set, data_word, 2'b00};
                if (burst_done) begin
                    tag_we     = 1'b1;               // install tag, valid and clean
                    lru_access = 1'b1;               // fill touches the victim way
                    next_state = IDLE;
                end else begin
                    mem_req.ren = 1'b1;
                    data_we     = ~mem_busy;
                    burst_step  = ~mem_busy;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

// File: source/data_array.sv
// line data storage, one word read and one word write per cycle
// read is combinational, write lands on the next edge
`timescale 1ns/10ps

module data_array import l2_cache_pkg::*; #(
    parameter int  BLOCK_SIZE = 4,
    parameter int  ASSOC      = 4,
    parameter int  N_SETS     = 8,
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int WAY_BITS   = $clog2(ASSOC)
) (
    input  logic                  CLK,
    input  logic [SET_BITS-1:0]   set_idx,
    input  logic [WAY_BITS-1:0]   way,
    input  logic [BLOCK_BITS-1:0] word,   // word within line
    input  logic                  we,
    input  word_t                 wdata,
    output word_t                 rdata
);
    word_t mem [N_SETS][ASSOC][BLOCK_SIZE];  // set, way, word

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[set_idx][way][word] <= wdata;
        end
    end

    assign rdata = mem[set_idx][way][word];

endmodule

// File: source/l2_cache.sv
// set-associative write-back cache between processor and memory word buses
// parameters set here are passed down to every block
`timescale 1ns/10ps

module l2_cache import l2_cache_pkg::*; #(
    parameter int    BLOCK_SIZE          = 4,             // words per line
    parameter int    ASSOC               = 4,             // ways per set
    parameter int    N_SETS              = 8,             // sets
    parameter addr_t NONCACHE_START_ADDR = 32'h8000_0000  // first uncached address
) (
    input  logic      CLK,
    input  logic      nRST,
    input  proc_req_t proc_req,
    output word_t     proc_rdata,
    output logic      proc_busy,
    output mem_req_t  mem_req,
    input  word_t     mem_rdata,
    input  logic      mem_busy
);
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int WAY_BITS   = $clog2(ASSOC);
    localparam int TAG_BITS   = WORD_SIZE - SET_BITS - BLOCK_BITS - 2;

    logic                  hit, victim_dirty;
    logic [WAY_BITS-1:0]   hit_way, victim_way, data_way;
    logic [TAG_BITS-1:0]   victim_tag;
    logic [BLOCK_BITS:0]   word_idx;  // one extra bit to reach BLOCK_SIZE
    logic [BLOCK_BITS-1:0] data_word;
    logic                  burst_done, burst_start, burst_step;
    logic                  tag_we, tag_dirty_we, data_we, lru_access;
    word_t                 data_wdata, rd_word;
    logic [SET_BITS-1:0]   set_idx;

    assign set_idx = proc_req.addr[BLOCK_BITS+2 +: SET_BITS];  // index field of request

    cache_ctrl #(
        .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC), .N_SETS(N_SETS),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) ctrl_inst (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .proc_rdata(proc_rdata), .proc_busy(proc_busy),
        .mem_req(mem_req), .mem_rdata(mem_rdata), .mem_busy(mem_busy),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .word_idx(word_idx), .burst_done(burst_done),
        .burst_start(burst_start), .burst_step(burst_step),
        .tag_we(tag_we), .tag_dirty_we(tag_dirty_we), .data_we(data_we),
        .data_way(data_way), .data_word(data_word), .data_wdata(data_wdata),
        .rd_word(rd_word), .lru_access(lru_access)
    );

    burst_counter #(.BLOCK_SIZE(BLOCK_SIZE)) burst_inst (
        .CLK(CLK), .nRST(nRST), .start(burst_start), .step(burst_step),
        .word_idx(word_idx), .done(burst_done)
    );

    tag_array #(.BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC), .N_SETS(N_SETS)) tag_inst (
        .CLK(CLK), .nRST(nRST), .addr(proc_req.addr), .victim_way(victim_way),
        .tag_we(tag_we), .dirty_we(tag_dirty_we), .dirty_val(1'b1),  // only write hits dirty
        .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    data_array #(.BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC), .N_SETS(N_SETS)) data_inst (
        .CLK(CLK), .set_idx(set_idx), .way(data_way), .word(data_word),
        .we(data_we), .wdata(data_wdata), .rdata(rd_word)
    );

    lru_order #(.ASSOC(ASSOC), .N_SETS(N_SETS)) lru_inst (
        .CLK(CLK), .nRST(nRST), .set_idx(set_idx), .access(lru_access),
        .way(data_way), .victim_way(victim_way)  // hit way or filled victim
    );

endmodule

// File: source/l2_cache_pkg.sv
// shared types for the l2 cache
// word and address types, bus request structs and controller states
package l2_cache_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////////////////////////
    parameter int WORD_SIZE = 32;  // bits per word

    typedef logic [WORD_SIZE-1:0] word_t;  // one data word
    typedef logic [31:0]          addr_t;  // byte address

    ////////////////////////////////////////////////////////////
    // bus requests
    ////////////////////////////////////////////////////////////
    // processor side, held until busy is seen low
    typedef struct packed {
        logic  ren;    // read request
        logic  wen;    // write request
        addr_t addr;   // byte address
        word_t wdata;  // write word
    } proc_req_t;

    // memory side, same layout as the processor request
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    ////////////////////////////////////////////////////////////
    // controller FSM
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE,        // wait for request, pass-through served here
        HIT,         // answer processor, one cycle
        WRITE_BACK,  // dirty victim out to memory
        FETCH        // new line in from memory
    } cache_state_t;

endpackage

// File: source/lru_order.sv
// least-recently-used order of ways per set
// head of the list is the victim, an access moves a way to the tail
`timescale 1ns/10ps

module lru_order #(
    parameter int  ASSOC    = 4,
    parameter int  N_SETS   = 8,
    localparam int SET_BITS = $clog2(N_SETS),
    localparam int WAY_BITS = $clog2(ASSOC)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [SET_BITS-1:0] set_idx,
    input  logic                access,     // one pulse per hit or fill
    input  logic [WAY_BITS-1:0] way,        // way just used
    output logic [WAY_BITS-1:0] victim_way
);
    // entry 0 least recent, entry ASSOC-1 most recent
    logic [ASSOC-1:0][WAY_BITS-1:0] order [N_SETS];
    logic [ASSOC-1:0][WAY_BITS-1:0] cur, nxt;
    logic                           shift;

    assign cur        = order[set_idx];
    assign victim_way = cur[0];

    always_comb begin
        shift = 1'b0;
        nxt   = cur;
        for (int i = 0; i < ASSOC-1; i++) begin
            if (cur[i] == way) begin
                shift = 1'b1;                   // entries behind it move up
            end
            nxt[i] = shift ? cur[i+1] : cur[i];
        end
        nxt[ASSOC-1] = way;                     // used way becomes most recent
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                for (int i = 0; i < ASSOC; i++) begin
                    order[s][i] <= WAY_BITS'(i);  // way 0 first victim
                end
            end
        end else if (access) begin
            order[set_idx] <= nxt;
        end
    end

endmodule

// File: source/tag_array.sv
// per-way tags with valid and dirty bits
// hit compare over the indexed set plus victim tag and dirty lookup
`timescale 1ns/10ps

module tag_array import l2_cache_pkg::*; #(
    parameter int  BLOCK_SIZE = 4,
    parameter int  ASSOC      = 4,
    parameter int  N_SETS     = 8,
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int WAY_BITS   = $clog2(ASSOC),
    localparam int TAG_BITS   = WORD_SIZE - SET_BITS - BLOCK_BITS - 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  addr_t               addr,
    input  logic [WAY_BITS-1:0] victim_way,
    input  logic                tag_we,        // fill done
    input  logic                dirty_we,      // update dirty of hit way
    input  logic                dirty_val,
    output logic                hit,
    output logic [WAY_BITS-1:0] hit_way,
    output logic                victim_dirty,
    output logic [TAG_BITS-1:0] victim_tag
);
    logic [ASSOC-1:0]    valid [N_SETS];
    logic [ASSOC-1:0]    dirty [N_SETS];
    logic [TAG_BITS-1:0] tags  [N_SETS][ASSOC];
    logic [TAG_BITS-1:0] tag;
    logic [SET_BITS-1:0] set;

    assign tag = addr[WORD_SIZE-1 -: TAG_BITS];
    assign set = addr[BLOCK_BITS+2 +: SET_BITS];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (valid[set][i] && tags[set][i] == tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(i);
            end
        end
    end

    assign victim_dirty = dirty[set][victim_way];
    assign victim_tag   = tags[set][victim_way];

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else if (tag_we) begin
            valid[set][victim_way] <= 1'b1;  // new line is clean
            dirty[set][victim_way] <= 1'b0;
        end else if (dirty_we && hit) begin
            dirty[set][hit_way] <= dirty_val;
        end
    end

    always_ff @(posedge CLK) begin
        if (tag_we) begin
            tags[set][victim_way] <= tag;
        end
    end

endmodule

// File: verification/tb_clock.sv
// clock and reset source for the cache testbench
// 10 ns clock, reset held low for the first RESET_CYCLES edges
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 10,  // ns
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;                    // in reset from time zero
        repeat (RESET_CYCLES) @(posedge CLK);
        #1 nRST = 1'b1;                 // release just after an edge
    end

    always #(PERIOD/2) CLK = ~CLK;

endmodule

// File: verification/tb_l2_cache.sv
// l2 cache testbench driving a table of processor accesses in a loop
// each entry carries expected read data, memory transfer counts and hit latency
`timescale 1ns/10ps

module tb_l2_cache import l2_cache_pkg::*; ();
    localparam int WAIT_LIMIT = 200;          // cycles per access

    typedef enum logic {OP_RD, OP_WR} op_t;
    typedef struct packed {
        op_t         op;
        logic        hit;                     // expect one-cycle hit latency
        addr_t       addr;
        word_t       wdata;
        word_t       rdata;                   // checked on reads only
        logic [31:0] reads;                   // memory reads during the access
        logic [31:0] writes;                  // memory writes during the access
    } step_t;

    logic      CLK, nRST, proc_busy, mem_busy;
    proc_req_t proc_req;
    word_t     proc_rdata, mem_rdata;
    mem_req_t  mem_req;
    int        mem_reads, mem_writes;
    int        errors, timeouts, cur_step;
    step_t     steps [$];

    tb_clock #(.PERIOD(10), .RESET_CYCLES(4)) clk_inst (.CLK(CLK), .nRST(nRST));

    tb_mem_model mem_inst (
        .CLK(CLK), .nRST(nRST), .mem_req(mem_req), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy), .read_count(mem_reads), .write_count(mem_writes)
    );

    l2_cache #(.BLOCK_SIZE(4), .ASSOC(4), .N_SETS(8)) l2_cache_inst (
        .CLK(CLK), .nRST(nRST), .proc_req(proc_req), .proc_rdata(proc_rdata),
        .proc_busy(proc_busy), .mem_req(mem_req), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %0t step %0d %s: got %h expected %h",
                     $time, cur_step, name, actual, expected);
            errors++;
        end
    endtask

    function automatic void add_step(input op_t op, input logic hit, input addr_t addr,
                                     input word_t wdata, input word_t rdata,
                                     input int reads, input int writes);
        step_t s;
        s.op     = op;
        s.hit    = hit;
        s.addr   = addr;
        s.wdata  = wdata;
        s.rdata  = rdata;
        s.reads  = reads;
        s.writes = writes;
        steps.push_back(s);
    endfunction

    ////////////////////////////////////////////////////////////
    // drive one access and wait for busy low before checking
    ////////////////////////////////////////////////////////////
    task automatic run_step(input step_t s, output bit ok);
        int    cycles;
        int    reads0;
        int    writes0;
        word_t rdata;
        bit    done;
        reads0         = mem_reads;
        writes0        = mem_writes;
        proc_req.ren   = (s.op == OP_RD);
        proc_req.wen   = (s.op == OP_WR);
        proc_req.addr  = s.addr;
        proc_req.wdata = s.wdata;
        cycles         = 0;
        done           = 1'b0;
        rdata          = '0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge CLK);                          // busy stable mid-cycle
            cycles++;
            if (!proc_busy) begin
                done  = 1'b1;
                rdata = proc_rdata;
            end
        end
        ok = done;
        if (!done) begin
            $display("timeout at step %0d: proc_busy never went low", cur_step);
            timeouts++;
        end else begin
            @(posedge CLK);                          // access taken here
            #1;
            if (s.op == OP_RD) check_value("proc_rdata", rdata, s.rdata);
            if (s.hit) check_value("hit cycles", 32'(cycles), 32'd2);
            check_value("mem reads", 32'(mem_reads - reads0), s.reads);
            check_value("mem writes", 32'(mem_writes - writes0), s.writes);
        end
    endtask

    initial begin
        int cycles;
        bit ok;
        proc_req = '0;
        errors   = 0;
        timeouts = 0;
        cur_step = -1;
        // set 0 lines A=000 B=080 C=100 D=180 E=200 F=280
        add_step(OP_RD, 0, 32'h0000_0004, 0, 32'h5a5a_0004, 4, 0);  // fill A
        add_step(OP_RD, 1, 32'h0000_000c, 0, 32'h5a5a_000c, 0, 0);
        add_step(OP_WR, 1, 32'h0000_0008, 32'h1111_2222, 0, 0, 0);  // A dirty
        add_step(OP_RD, 1, 32'h0000_0008, 0, 32'h1111_2222, 0, 0);
        add_step(OP_RD, 0, 32'h0000_0080, 0, 32'h5a5a_0080, 4, 0);  // B
        add_step(OP_RD, 0, 32'h0000_0100, 0, 32'h5a5a_0100, 4, 0);  // C
        add_step(OP_RD, 0, 32'h0000_0180, 0, 32'h5a5a_0180, 4, 0);  // D fills the set
        add_step(OP_RD, 1, 32'h0000_0000, 0, 32'h5a5a_0000, 0, 0);  // retouch A
        add_step(OP_RD, 0, 32'h0000_0200, 0, 32'h5a5a_0200, 4, 0);  // E evicts B
        add_step(OP_RD, 1, 32'h0000_0008, 0, 32'h1111_2222, 0, 0);  // A kept
        add_step(OP_RD, 1, 32'h0000_0104, 0, 32'h5a5a_0104, 0, 0);
        add_step(OP_RD, 1, 32'h0000_0184, 0, 32'h5a5a_0184, 0, 0);
        add_step(OP_RD, 1, 32'h0000_0204, 0, 32'h5a5a_0204, 0, 0);  // A now lru
        add_step(OP_RD, 0, 32'h0000_0280, 0, 32'h5a5a_0280, 4, 4);  // F evicts dirty A
        add_step(OP_RD, 0, 32'h0000_0008, 0, 32'h1111_2222, 4, 0);  // A from memory
        add_step(OP_RD, 0, 32'h0000_0084, 0, 32'h5a5a_0084, 4, 0);  // B was gone
        add_step(OP_WR, 0, 32'h8000_0010, 32'hcafe_f00d, 0, 0, 1);  // uncached
        add_step(OP_RD, 0, 32'h8000_0010, 0, 32'hcafe_f00d, 1, 0);
        add_step(OP_RD, 0, 32'h8000_0020, 0, 32'hda5a_0020, 1, 0);

        cycles = 0;
        while (nRST !== 1'b1 && cycles < 20) begin
            @(posedge CLK);
            cycles++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was never released");
            timeouts++;
        end else begin
            @(posedge CLK);
            #1;
            check_value("proc_busy after reset", 32'(proc_busy), 32'd1);
            check_value("mem_req.ren after reset", 32'(mem_req.ren), 32'd0);
            check_value("mem_req.wen after reset", 32'(mem_req.wen), 32'd0);
            for (int i = 0; i < steps.size(); i++) begin
                cur_step = i;
                run_step(steps[i], ok);
                if (!ok) break;
            end
            proc_req = '0;
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verification/tb_mem_model.sv
// word memory behind the cache using the same busy handshake as the cache bus
// seeded random busy stalls and unwritten words read back as address xor 5a5a_0000
`timescale 1ns/10ps

module tb_mem_model import l2_cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output word_t    mem_rdata,
    output logic     mem_busy,
    output int       read_count,   // reads taken
    output int       write_count   // writes taken
);
    word_t store [addr_t];          // only written words live here
    addr_t word_addr;
    logic  stall;
    int    seed;

    initial seed = 32'ha27b;

    assign word_addr = {mem_req.addr[31:2], 2'b00};          // whole words only
    assign mem_busy  = (mem_req.ren | mem_req.wen) & stall;  // stall only when asked

    always_comb begin
        if (store.exists(word_addr)) begin
            mem_rdata = store[word_addr];
        end else begin
            mem_rdata = word_addr ^ 32'h5a5a_0000;  // initial content
        end
    end

    ////////////////////////////////////////////////////////////
    // stalls, write storage and transfer counters
    ////////////////////////////////////////////////////////////
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stall       <= 1'b0;
            read_count  <= 0;
            write_count <= 0;
        end else begin
            stall <= (($random(seed) & 32'd3) == 32'd0);   // busy about one cycle in four
            if (!mem_busy && mem_req.wen) begin
                store[word_addr] = mem_req.wdata;       // word readable from here on
                write_count <= write_count + 1;
            end else if (!mem_busy && mem_req.ren) begin
                read_count <= read_count + 1;
            end
        end
    end

endmodule
